/* verilog/fpadd_pkg.sv */
package fpadd_pkg;

    // ==================================================
    // binary32 format
    // ==================================================

    localparam int EXP_W   = 8;                   // biased exponent field.
    localparam int MAN_W   = 23;                  // stored fraction bits.
    localparam int SIG_W   = MAN_W + 1;           // fraction plus the hidden bit.
    localparam int ALIGN_W = 2 * SIG_W;           // significand with 24 bits below it.
    localparam int SUM_W   = ALIGN_W + 1;         // room for the carry of an add.
    localparam int MAX_EXP = (1 << EXP_W) - 2;    // all ones is kept for inf and NaN.

    typedef struct packed {
        logic             sign;
        logic [EXP_W-1:0] exponent;
        logic [MAN_W-1:0] mantissa;
    } float32_t;

    localparam float32_t CANONICAL_NAN = 32'h7FC0_0000;   // quiet NaN, positive sign.

    // ==================================================
    // operand classes
    // ==================================================

    typedef enum logic [1:0] {
        CLASS_NORMAL,                             // zero, subnormal or normal.
        CLASS_INF,
        CLASS_NAN
    } operand_class_t;

    function automatic operand_class_t classify(input float32_t op);
        operand_class_t cls;
        if (op.exponent != '1) begin
            cls = CLASS_NORMAL;
        end else if (op.mantissa == '0) begin
            cls = CLASS_INF;
        end else begin
            cls = CLASS_NAN;                      // any non-zero payload counts as NaN.
        end
        return cls;
    endfunction

endpackage

/* verilog/fpadd_stage_if.sv */
`timescale 1ns/1ps

// Operands after ordering, on their way into the alignment shifter.
interface fpadd_swap_if;
    import fpadd_pkg::*;

    logic             sign;                       // sign of the larger magnitude.
    logic [EXP_W-1:0] exponent;                   // exponent of the larger magnitude.
    logic [SIG_W-1:0] major_sig;
    logic [SIG_W-1:0] minor_sig;
    logic [EXP_W-1:0] shift_amt;                  // exponent difference, never negative.
    logic             eff_sub;                    // effective signs differ.

    modport source (
        output sign, exponent, major_sig, minor_sig, shift_amt, eff_sub
    );

    modport sink (
        input  sign, exponent, major_sig, minor_sig, shift_amt, eff_sub
    );
endinterface

// Operands after the minor significand has been lined up with the major one.
interface fpadd_aligned_if;
    import fpadd_pkg::*;

    logic               sign;
    logic [EXP_W-1:0]   exponent;
    logic [SIG_W-1:0]   major_sig;
    logic [ALIGN_W-1:0] minor_aligned;            // keeps the bits shifted past the lsb.
    logic               eff_sub;

    modport source (
        output sign, exponent, major_sig, minor_aligned, eff_sub
    );

    modport sink (
        input  sign, exponent, major_sig, minor_aligned, eff_sub
    );
endinterface

/* verilog/fpadd_ctrl.sv */
`timescale 1ns/1ps

module fpadd_ctrl (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                valid_i,
    input  logic                sub_i,
    input  fpadd_pkg::float32_t operand_a_i,
    input  fpadd_pkg::float32_t operand_b_i,
    input  fpadd_pkg::float32_t norm_result_i,
    input  logic                norm_overflow_i,
    input  logic                norm_underflow_i,
    output logic                valid_o,
    output logic                invalid_o,
    output logic                overflow_o,
    output logic                underflow_o,
    output fpadd_pkg::float32_t result_o
);
    import fpadd_pkg::*;

    typedef struct packed {
        logic invalid;                            // NaN in, or inf minus inf.
        logic is_inf;                             // at least one operand is infinite.
        logic inf_sign;                           // sign of that infinity.
    } special_t;

    // ==================================================
    // operand classification
    // ==================================================

    operand_class_t class_a;
    operand_class_t class_b;
    logic           b_sign_eff;
    special_t       special_in;

    assign class_a    = classify(operand_a_i);
    assign class_b    = classify(operand_b_i);
    assign b_sign_eff = operand_b_i.sign ^ sub_i;   // subtraction flips the sign of B.

    assign special_in.invalid  = (class_a == CLASS_NAN) || (class_b == CLASS_NAN) ||
                                 ((class_a == CLASS_INF) && (class_b == CLASS_INF) &&
                                  (operand_a_i.sign != b_sign_eff));
    assign special_in.is_inf   = (class_a == CLASS_INF) || (class_b == CLASS_INF);
    assign special_in.inf_sign = (class_a == CLASS_INF) ? operand_a_i.sign : b_sign_eff;

    // ==================================================
    // four-deep delay, one slot per datapath stage
    // ==================================================

    logic     [3:0] valid_pipe;
    special_t [3:0] special_pipe;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[2:0], valid_i};
        end
    end

    always_ff @(posedge clk_i) begin
        special_pipe <= {special_pipe[2:0], special_in};
    end

    assign valid_o = valid_pipe[3];

    // Special cases override whatever the datapath produced.
    always_comb begin
        result_o    = norm_result_i;
        invalid_o   = 1'b0;
        overflow_o  = norm_overflow_i;
        underflow_o = norm_underflow_i;
        if (special_pipe[3].invalid) begin
            result_o    = CANONICAL_NAN;
            invalid_o   = 1'b1;
            overflow_o  = 1'b0;
            underflow_o = 1'b0;
        end else if (special_pipe[3].is_inf) begin
            result_o.sign     = special_pipe[3].inf_sign;
            result_o.exponent = '1;
            result_o.mantissa = '0;
            overflow_o        = 1'b0;               // an infinite input is not an overflow.
            underflow_o       = 1'b0;
        end
    end

endmodule

/* verilog/fpadd_swap.sv */
`timescale 1ns/1ps

module fpadd_swap (
    input  logic                clk_i,
    input  logic                sub_i,
    input  fpadd_pkg::float32_t operand_a_i,
    input  fpadd_pkg::float32_t operand_b_i,
    fpadd_swap_if.source        swap_o
);
    import fpadd_pkg::*;

    float32_t operand_b_eff;
    float32_t major_op;
    float32_t minor_op;
    logic     a_is_major;
    logic     major_hidden;
    logic     minor_hidden;

    always_comb begin
        operand_b_eff      = operand_b_i;
        operand_b_eff.sign = operand_b_i.sign ^ sub_i;   // a - b is a + (-b).
    end

    // Larger exponent wins, then larger fraction; on a full tie A stays first.
    assign a_is_major = (operand_a_i.exponent > operand_b_i.exponent) ||
                        ((operand_a_i.exponent == operand_b_i.exponent) &&
                         (operand_a_i.mantissa >= operand_b_i.mantissa));

    assign major_op = a_is_major ? operand_a_i   : operand_b_eff;
    assign minor_op = a_is_major ? operand_b_eff : operand_a_i;

    assign major_hidden = (major_op.exponent != '0);   // subnormals have no leading one.
    assign minor_hidden = (minor_op.exponent != '0);

    always_ff @(posedge clk_i) begin
        swap_o.sign      <= major_op.sign;
        swap_o.exponent  <= major_op.exponent;
        swap_o.major_sig <= {major_hidden, major_op.mantissa};
        swap_o.minor_sig <= {minor_hidden, minor_op.mantissa};
        swap_o.shift_amt <= major_op.exponent - minor_op.exponent;   // ordering keeps it >= 0.
        swap_o.eff_sub   <= operand_a_i.sign ^ operand_b_eff.sign;
    end

endmodule

/* verilog/fpadd_align.sv */
`timescale 1ns/1ps

module fpadd_align (
    input  logic            clk_i,
    fpadd_swap_if.sink      swap_i,
    fpadd_aligned_if.source aligned_o
);
    import fpadd_pkg::*;

    logic [ALIGN_W-1:0] minor_field;
    logic [ALIGN_W-1:0] minor_shifted;

    // The lower half catches the bits that fall off the significand.
    assign minor_field = {swap_i.minor_sig, {(ALIGN_W - SIG_W){1'b0}}};

    assign minor_shifted = (swap_i.shift_amt >= SIG_W) ? '0 :
                           (minor_field >> swap_i.shift_amt);   // too far right is all zero.

    always_ff @(posedge clk_i) begin
        aligned_o.sign          <= swap_i.sign;
        aligned_o.exponent      <= swap_i.exponent;
        aligned_o.major_sig     <= swap_i.major_sig;
        aligned_o.minor_aligned <= minor_shifted;
        aligned_o.eff_sub       <= swap_i.eff_sub;
    end

endmodule

/* verilog/fpadd_mant_add.sv */
`timescale 1ns/1ps

module fpadd_mant_add (
    input  logic                          clk_i,
    fpadd_aligned_if.sink                 aligned_i,
    output logic                          sign_o,
    output logic [fpadd_pkg::EXP_W-1:0]   exponent_o,
    output logic [fpadd_pkg::SUM_W-1:0]   sum_o
);
    import fpadd_pkg::*;

    logic [SUM_W-1:0] major_ext;
    logic [SUM_W-1:0] minor_ext;
    logic [SUM_W-1:0] sum_next;

    // Both operands sit in the same 49-bit frame with the carry bit on top.
    assign major_ext = {1'b0, aligned_i.major_sig, {(ALIGN_W - SIG_W){1'b0}}};
    assign minor_ext = {1'b0, aligned_i.minor_aligned};

    // The major magnitude is never below the minor one, so the difference
    // cannot wrap and no negation of the result is needed.
    assign sum_next = aligned_i.eff_sub ? (major_ext - minor_ext) :
                                          (major_ext + minor_ext);

    always_ff @(posedge clk_i) begin
        sign_o     <= aligned_i.sign;
        exponent_o <= aligned_i.exponent;
        sum_o      <= sum_next;                  // full width, nothing truncated yet.
    end

endmodule

/* verilog/fpadd_normalize.sv */
`timescale 1ns/1ps

module fpadd_normalize (
    input  logic                          clk_i,
    input  logic                          sign_i,
    input  logic [fpadd_pkg::EXP_W-1:0]   exponent_i,
    input  logic [fpadd_pkg::SUM_W-1:0]   sum_i,
    output fpadd_pkg::float32_t           result_o,
    output logic                          overflow_o,
    output logic                          underflow_o
);
    import fpadd_pkg::*;

    localparam int LZ_W = $clog2(ALIGN_W + 1);   // counts 0 up to 48.

    logic [LZ_W-1:0]         lead_zeros;
    logic [EXP_W:0]          exp_inc;
    logic signed [EXP_W+1:0] exp_rem;
    logic [ALIGN_W-1:0]      sum_shifted;
    float32_t                result_next;
    logic                    overflow_next;
    logic                    underflow_next;

    // ==================================================
    // leading-zero count over the 48-bit field
    // ==================================================

    always_comb begin
        lead_zeros = LZ_W'(ALIGN_W);             // all zero unless a one is found.
        for (int i = 0; i < ALIGN_W; i++) begin
            if (sum_i[i]) begin
                lead_zeros = LZ_W'(ALIGN_W - 1 - i);   // the highest set bit wins.
            end
        end
    end

    assign exp_inc     = {1'b0, exponent_i} + 1'b1;
    assign exp_rem     = $signed({2'b00, exponent_i}) -
                         $signed({{(EXP_W + 2 - LZ_W){1'b0}}, lead_zeros});
    assign sum_shifted = sum_i[ALIGN_W-1:0] << lead_zeros;

    // ==================================================
    // result selection
    // ==================================================

    always_comb begin
        result_next.sign     = sign_i;
        result_next.exponent = '0;               // a zero sum keeps these values.
        result_next.mantissa = '0;
        overflow_next        = 1'b0;
        underflow_next       = 1'b0;
        if (sum_i[SUM_W-1]) begin
            if (exp_inc > MAX_EXP) begin
                result_next.exponent = '1;       // carry pushed past the largest finite value.
                overflow_next        = 1'b1;
            end else begin
                result_next.exponent = exp_inc[EXP_W-1:0];
                result_next.mantissa = sum_i[ALIGN_W-1 -: MAN_W];   // one step to the right.
            end
        end else if (sum_i != '0) begin
            if (exp_rem <= 0) begin
                // Not enough exponent range to bring the leading one up.
                underflow_next       = 1'b1;
                result_next.mantissa = sum_i[ALIGN_W-2 -: MAN_W];
            end else begin
                result_next.exponent = exp_rem[EXP_W-1:0];
                result_next.mantissa = sum_shifted[ALIGN_W-2 -: MAN_W];   // hidden bit dropped.
            end
        end
    end

    always_ff @(posedge clk_i) begin
        result_o    <= result_next;
        overflow_o  <= overflow_next;
        underflow_o <= underflow_next;
    end

endmodule

/* verilog/fpadd_top.sv */
`timescale 1ns/1ps

module fpadd_top (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                valid_i,
    input  logic                sub_i,
    input  fpadd_pkg::float32_t operand_a_i,
    input  fpadd_pkg::float32_t operand_b_i,
    output logic                valid_o,
    output logic                invalid_o,
    output logic                overflow_o,
    output logic                underflow_o,
    output fpadd_pkg::float32_t result_o
);
    import fpadd_pkg::*;

    fpadd_swap_if    swap_bus ();                 // stage 1 to stage 2.
    fpadd_aligned_if aligned_bus ();              // stage 2 to stage 3.

    logic             mant_sign;                  // stage 3 to stage 4.
    logic [EXP_W-1:0] mant_exponent;
    logic [SUM_W-1:0] mant_sum;

    float32_t         norm_result;                // stage 4 to the output select.
    logic             norm_overflow;
    logic             norm_underflow;

    fpadd_ctrl i_ctrl (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .valid_i          (valid_i),
        .sub_i            (sub_i),
        .operand_a_i      (operand_a_i),
        .operand_b_i      (operand_b_i),
        .norm_result_i    (norm_result),
        .norm_overflow_i  (norm_overflow),
        .norm_underflow_i (norm_underflow),
        .valid_o          (valid_o),
        .invalid_o        (invalid_o),
        .overflow_o       (overflow_o),
        .underflow_o      (underflow_o),
        .result_o         (result_o)
    );

    fpadd_swap i_swap (
        .clk_i       (clk_i),
        .sub_i       (sub_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .swap_o      (swap_bus.source)
    );

    fpadd_align i_align (
        .clk_i     (clk_i),
        .swap_i    (swap_bus.sink),
        .aligned_o (aligned_bus.source)
    );

    fpadd_mant_add i_mant_add (
        .clk_i      (clk_i),
        .aligned_i  (aligned_bus.sink),
        .sign_o     (mant_sign),
        .exponent_o (mant_exponent),
        .sum_o      (mant_sum)
    );

    fpadd_normalize i_normalize (
        .clk_i       (clk_i),
        .sign_i      (mant_sign),
        .exponent_i  (mant_exponent),
        .sum_i       (mant_sum),
        .result_o    (norm_result),
        .overflow_o  (norm_overflow),
        .underflow_o (norm_underflow)
    );

endmodule

/* verif/fpadd_checker.sv */
`timescale 1ns/1ps

module fpadd_checker (
    input logic                clk_i,
    input logic                rst_n_i,
    input logic                valid_i,
    input logic                valid_o,
    input logic                invalid_o,
    input logic                overflow_o,
    input fpadd_pkg::float32_t result_o
);
    import fpadd_pkg::*;

    // ==================================================
    // output timing and special results
    // ==================================================

    valid_latency_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_o == $past(valid_i, 4))
        else $error("valid_o does not match valid_i from four cycles before");

    invalid_nan_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (valid_o && invalid_o) |-> (result_o == CANONICAL_NAN))
        else $error("invalid_o is set but result_o is not the canonical NaN");

    invalid_overflow_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_o |-> !(invalid_o && overflow_o))
        else $error("invalid_o and overflow_o are set together");

endmodule

bind fpadd_ctrl fpadd_checker i_checker (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .valid_i    (valid_i),
    .valid_o    (valid_o),
    .invalid_o  (invalid_o),
    .overflow_o (overflow_o),
    .result_o   (result_o)
);

/* include/fpadd_tb_model.svh */
`ifndef FPADD_TB_MODEL_SVH
`define FPADD_TB_MODEL_SVH

typedef struct packed {
    float32_t result;
    logic     invalid;
    logic     overflow;
    logic     underflow;
} expected_t;

// Expected outputs of one operation, built from the format rules step by step.
function automatic expected_t expect_sum(input float32_t a, input float32_t b, input logic sub);
    expected_t          res;
    float32_t           b_eff;
    float32_t           big;
    float32_t           lesser;
    logic               a_inf;
    logic               b_inf;
    logic               any_nan;
    logic [ALIGN_W-1:0] small_field;
    logic [SUM_W-1:0]   total;
    int                 e;
    int                 lz;
    res        = '0;
    b_eff      = b;
    b_eff.sign = b.sign ^ sub;                          // subtraction adds the negated B.
    a_inf      = (a.exponent == 8'hff) && (a.mantissa == 23'h0);
    b_inf      = (b.exponent == 8'hff) && (b.mantissa == 23'h0);
    any_nan    = ((a.exponent == 8'hff) && !a_inf) || ((b.exponent == 8'hff) && !b_inf);
    if (any_nan || (a_inf && b_inf && (a.sign != b_eff.sign))) begin
        res.result  = CANONICAL_NAN;
        res.invalid = 1'b1;
    end else if (a_inf || b_inf) begin
        res.result = {(a_inf ? a.sign : b_eff.sign), 8'hff, 23'h0};
    end else begin
        if ({a.exponent, a.mantissa} >= {b.exponent, b.mantissa}) begin
            big    = a;                                 // a full tie keeps A in front.
            lesser = b_eff;
        end else begin
            big    = b_eff;
            lesser = a;
        end
        e           = int'(big.exponent);
        small_field = '0;
        if (e - int'(lesser.exponent) < 24) begin
            small_field = {(lesser.exponent != 8'h0), lesser.mantissa, 24'h0} >>
                          (e - int'(lesser.exponent));
        end
        total = {1'b0, (big.exponent != 8'h0), big.mantissa, 24'h0};
        if (big.sign == lesser.sign) begin
            total = total + {1'b0, small_field};
        end else begin
            total = total - {1'b0, small_field};    // never below zero after ordering.
        end
        res.result.sign = big.sign;
        if (total[SUM_W-1] && (e + 1 > MAX_EXP)) begin
            res.result.exponent = 8'hff;            // the carry leaves the finite range.
            res.overflow        = 1'b1;
        end else if (total[SUM_W-1]) begin
            res.result.exponent = 8'(e + 1);
            res.result.mantissa = total[47:25];
        end else if (total != '0) begin
            lz = 0;
            while (!total[47 - lz]) begin
                lz++;
            end
            if (e - lz <= 0) begin
                res.result.mantissa = total[46:24];  // left where it is, exponent stays 0.
                res.underflow       = 1'b1;
            end else begin
                total               = total << lz;
                res.result.exponent = 8'(e - lz);
                res.result.mantissa = total[46:24];
            end
        end
    end
    return res;
endfunction

`endif

/* verif/fpadd_tb.sv */
`timescale 1ns/1ps

module fpadd_tb;
    import fpadd_pkg::*;

    `include "fpadd_tb_model.svh"

    localparam int NUM_OPS    = 3000;
    localparam int MAX_CYCLES = NUM_OPS * 8 / 3 + 100;   // about 75% of cycles carry an op.

    logic      clk_i;
    logic      rst_n_i;
    logic      valid_i;
    logic      sub_i;
    float32_t  operand_a_i;
    float32_t  operand_b_i;
    logic      valid_o;
    logic      invalid_o;
    logic      overflow_o;
    logic      underflow_o;
    float32_t  result_o;

    integer    seed;
    int        cycle_count;
    expected_t pending[$];                               // model results, oldest first.
    int        issued_at[$];

    fpadd_top i_dut (.*);

    always #20 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("ERROR: timeout after %0d cycles with results still missing", cycle_count);
            $display("Done: errors found");
            $fatal(1, "timeout");
        end
    end

    // ==================================================
    // checks
    // ==================================================

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, want);
            $display("Done: errors found");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_outputs();
        expected_t want;
        if (valid_o !== 1'b1) begin
            check_value("valid_o", 32'(valid_o), 32'h0);
        end else if (pending.size() == 0) begin
            $display("ERROR: valid_o is high but no operation is in flight");
            $display("Done: errors found");
            $fatal(1, "unexpected valid_o");
        end else begin
            want = pending.pop_front();
            check_value("valid_o latency", 32'(cycle_count - issued_at.pop_front()), 32'd4);
            check_value("result_o", result_o, want.result);
            check_value("invalid_o", 32'(invalid_o), 32'(want.invalid));
            check_value("overflow_o", 32'(overflow_o), 32'(want.overflow));
            check_value("underflow_o", 32'(underflow_o), 32'(want.underflow));
        end
    endtask

    // ==================================================
    // stimulus
    // ==================================================

    function automatic logic [7:0] edge_exponent(input int pick);
        return (pick == 0) ? 8'd0 : (pick == 1) ? 8'd254 : 8'd255;
    endfunction

    task automatic make_operands(input logic sub, output float32_t a, output float32_t b);
        int kind;
        a    = $random(seed);
        b    = $random(seed);
        kind = $unsigned($random(seed)) % 10;
        case (kind)
            0: begin
                a.exponent = edge_exponent($unsigned($random(seed)) % 3);
                b.exponent = edge_exponent($unsigned($random(seed)) % 3);
            end
            1: b.exponent = a.exponent;
            2: b.exponent = a.exponent + 8'($unsigned($random(seed)) % 5) - 8'd2;
            3: a = {a.sign, 8'hff, a.mantissa | 23'h1};            // NaN in A.
            4: begin
                a = {a.sign, 8'hff, 23'h0};
                if (b.mantissa[0]) begin
                    b = {b.sign, 8'hff, 23'h0};                     // inf against inf.
                end
            end
            5: b = {b.sign, 8'hff, 23'h0};
            6: b = {a.sign ^ sub ^ 1'b1, a.exponent, a.mantissa ^ 23'(b.mantissa[1:0])};
            7: b.exponent = a.exponent - 8'd24 - 8'($unsigned($random(seed)) % 8);
            8: begin
                a.exponent = 8'd254;                                // carry can overflow.
                b = {a.sign ^ sub, 8'd254 - 8'(b.mantissa[0]), b.mantissa};
            end
            default: ;
        endcase
    endtask

    initial begin
        float32_t a;
        float32_t b;
        logic     sub;
        logic     valid;
        int       ops_sent;
        seed        = 32'hc94a_230c;
        clk_i       = 1'b0;
        rst_n_i     = 1'b0;
        valid_i     = 1'b0;
        sub_i       = 1'b0;
        operand_a_i = '0;
        operand_b_i = '0;
        cycle_count = 0;
        ops_sent    = 0;
        repeat (5) begin
            @(negedge clk_i);
            check_value("valid_o", 32'(valid_o), 32'h0);            // held low in reset.
        end
        rst_n_i = 1'b1;
        while (ops_sent < NUM_OPS) begin
            @(negedge clk_i);
            check_outputs();
            sub   = 1'($random(seed));
            valid = ($unsigned($random(seed)) % 4) != 0;
            make_operands(sub, a, b);
            valid_i     = valid;
            sub_i       = sub;
            operand_a_i = a;
            operand_b_i = b;
            if (valid) begin
                pending.push_back(expect_sum(a, b, sub));
                issued_at.push_back(cycle_count);
                ops_sent++;
            end
        end
        while (pending.size() != 0) begin
            @(negedge clk_i);
            check_outputs();
            valid_i = 1'b0;
        end
        repeat (6) begin
            @(negedge clk_i);
            check_outputs();                                        // nothing more may come out.
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

/* fpadd.f */
+incdir+include
verilog/fpadd_pkg.sv
verilog/fpadd_stage_if.sv
verilog/fpadd_ctrl.sv
verilog/fpadd_swap.sv
verilog/fpadd_align.sv
verilog/fpadd_mant_add.sv
verilog/fpadd_normalize.sv
verilog/fpadd_top.sv
verif/fpadd_checker.sv
verif/fpadd_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the fpadd testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module fpadd_tb -f fpadd.f -Mdir obj_dir -o fpadd_sim

./obj_dir/fpadd_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Done: no errors$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
